//--- design/binMapper.sv
`timescale 1ns/1ps

module binMapper import hisPkg::*; #(
    parameter int stampWidth = 10,
    parameter int binBits    = 3
) (
    input  hisPhaseT             phase,
    input  logic [binBits-1:0]   windowBase,
    input  logic [stampWidth-1:0] roughData,
    input  logic                 wrEn,
    output logic [binBits-1:0]   binAddr,
    output logic                 binValid
);

    // bits left below the fine bin field
    localparam int fineShift = stampWidth - 2 * binBits;

    logic [binBits-1:0] coarseField;
    logic [binBits-1:0] fineField;
    logic               inWindow;

    // top bits pick the coarse bin
    assign coarseField = roughData[stampWidth-1 -: binBits];

    // next field down picks the fine bin inside the window
    assign fineField = roughData[fineShift +: binBits];

    // stamp falls in the window when its coarse bin is the coarse peak
    assign inWindow = (coarseField == windowBase);

    always_comb begin
        if (phase == phaseCoarse) begin
            // every strobe counts in the coarse pass
            binAddr  = coarseField;
            binValid = wrEn;
        end else begin
            // out-of-window stamps are rejected here
            // the accumulator still counts the strobe toward acqLength
            binAddr  = fineField;
            binValid = wrEn & inWindow;
        end
    end

endmodule

//--- design/hisAccumulator.sv
`timescale 1ns/1ps

module hisAccumulator import hisPkg::*; #(
    parameter int binBits    = 3,
    parameter int countWidth = 8,
    parameter int acqLength  = 16
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  binValid,
    input  logic [binBits-1:0]    binAddr,
    input  logic                  wrEn,
    input  logic [binBits-1:0]    scanAddr,
    input  logic                  peakDone,
    input  logic                  resDone,
    output hisPhaseT              phase,
    output logic                  scanStart,
    output logic [countWidth-1:0] scanCount,
    output logic                  busy
);

    localparam int numBins     = 2 ** binBits;
    localparam int acceptWidth = $clog2(acqLength + 1);

    localparam logic [acceptWidth-1:0] lastAccept = acceptWidth'(acqLength - 1);
    // saturation level of a bin
    localparam logic [countWidth-1:0]  countMax   = '1;

    accStateT               state;
    logic [acceptWidth-1:0] acceptCnt;
    logic [countWidth-1:0]  binCount [numBins];

    logic accept;
    logic lastStrobe;

    // strobes only count while collecting
    assign accept     = (state == stCollect) && wrEn;
    assign lastStrobe = accept && (acceptCnt == lastAccept);

    // anything but collecting means stamps are dropped
    assign busy = (state != stCollect);

    // read port for the peak finder
    assign scanCount = binCount[scanAddr];

    // controller
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= stCollect;
            phase     <= phaseCoarse;
            scanStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            case (state)
                stCollect: begin
                    // last strobe of the pass kicks off the scan
                    if (lastStrobe) begin
                        state     <= stScan;
                        scanStart <= 1'b1;
                    end
                end
                stScan: begin
                    if (peakDone) begin
                        if (phase == phaseCoarse) begin
                            // window is latched on this edge, go straight to fine pass
                            state <= stCollect;
                            phase <= phaseFine;
                        end else begin
                            state <= stHold;
                        end
                    end
                end
                stHold: begin
                    // wait for the four-phase result exchange to close
                    if (resDone) begin
                        state <= stCollect;
                        phase <= phaseCoarse;
                    end
                end
                default: begin
                    state <= stCollect;
                end
            endcase
        end
    end

    // accepted strobes per pass, in or out of the window
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acceptCnt <= '0;
        end else if (lastStrobe) begin
            acceptCnt <= '0;
        end else if (accept) begin
            acceptCnt <= acceptCnt + 1'b1;
        end
    end

    // bin counters
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numBins; i++) begin
                binCount[i] <= '0;
            end
        end else if (accept && binValid) begin
            // hold at the maximum instead of wrapping
            if (binCount[binAddr] != countMax) begin
                binCount[binAddr] <= binCount[binAddr] + 1'b1;
            end
        end else if (state == stScan && !scanStart) begin
            // read and clear, next pass starts empty
            // skip the scanStart cycle, scanAddr is stale there
            binCount[scanAddr] <= '0;
        end
    end

endmodule

//--- design/hisBuilder.sv
`timescale 1ns/1ps

module hisBuilder import hisPkg::*; #(
    parameter int stampWidth = 10,
    parameter int binBits    = 3,
    parameter int countWidth = 8,
    parameter int acqLength  = 16
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wrEn,
    input  logic [stampWidth-1:0] roughData,
    output logic [binBits-1:0]    peakCoarse,
    output logic [binBits-1:0]    peakFine,
    output logic [stampWidth-1:0] peakStamp,
    output logic                  resReq,
    input  logic                  resAck,
    output logic                  busy
);

    // mapper to accumulator
    logic [binBits-1:0]    binAddr;
    logic                  binValid;
    // pass select from the accumulator
    hisPhaseT              phase;
    // scan port
    logic                  scanStart;
    logic [countWidth-1:0] scanCount;
    logic [binBits-1:0]    scanAddr;
    logic                  peakDone;
    logic [binBits-1:0]    peakBin;
    // window stage back to mapper and controller
    logic [binBits-1:0]    windowBase;
    logic                  resDone;

    binMapper #(
        .stampWidth (stampWidth),
        .binBits    (binBits)
    ) i_binMapper (
        .phase      (phase),
        .windowBase (windowBase),
        .roughData  (roughData),
        .wrEn       (wrEn),
        .binAddr    (binAddr),
        .binValid   (binValid)
    );

    hisAccumulator #(
        .binBits    (binBits),
        .countWidth (countWidth),
        .acqLength  (acqLength)
    ) i_hisAccumulator (
        .clk       (clk),
        .rstN      (rstN),
        .binValid  (binValid),
        .binAddr   (binAddr),
        .wrEn      (wrEn),
        .scanAddr  (scanAddr),
        .peakDone  (peakDone),
        .resDone   (resDone),
        .phase     (phase),
        .scanStart (scanStart),
        .scanCount (scanCount),
        .busy      (busy)
    );

    peakFinder #(
        .binBits    (binBits),
        .countWidth (countWidth)
    ) i_peakFinder (
        .clk       (clk),
        .rstN      (rstN),
        .scanStart (scanStart),
        .scanCount (scanCount),
        .scanAddr  (scanAddr),
        .peakBin   (peakBin),
        .peakDone  (peakDone)
    );

    windowCalc #(
        .stampWidth (stampWidth),
        .binBits    (binBits)
    ) i_windowCalc (
        .clk        (clk),
        .rstN       (rstN),
        .phase      (phase),
        .peakDone   (peakDone),
        .peakBin    (peakBin),
        .resAck     (resAck),
        .windowBase (windowBase),
        .peakCoarse (peakCoarse),
        .peakFine   (peakFine),
        .peakStamp  (peakStamp),
        .resReq     (resReq),
        .resDone    (resDone)
    );

endmodule

//--- design/hisPkg.sv
package hisPkg;

    // which of the two passes is being built
    // coarse pass bins the whole stamp range
    // fine pass bins only the window picked by the coarse peak
    typedef enum logic {
        phaseCoarse = 1'b0,
        phaseFine   = 1'b1
    } hisPhaseT;

    // accumulator controller states
    typedef enum logic [1:0] {
        // counting accepted strobes
        stCollect = 2'd0,
        // peak finder walking the bins
        stScan    = 2'd1,
        // result offered, input ignored
        stHold    = 2'd2
    } accStateT;

endpackage

//--- design/peakFinder.sv
`timescale 1ns/1ps

module peakFinder #(
    parameter int binBits    = 3,
    parameter int countWidth = 8
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  scanStart,
    input  logic [countWidth-1:0] scanCount,
    output logic [binBits-1:0]    scanAddr,
    output logic [binBits-1:0]    peakBin,
    output logic                  peakDone
);

    localparam logic [binBits-1:0] lastBin = '1;

    logic                  scanActive;
    logic [countWidth-1:0] maxCount;
    logic [binBits-1:0]    bestAddr;

    // best address is final by the time peakDone is high
    assign peakBin = bestAddr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            scanActive <= 1'b0;
            scanAddr   <= '0;
            maxCount   <= '0;
            bestAddr   <= '0;
            peakDone   <= 1'b0;
        end else begin
            peakDone <= 1'b0;
            if (scanStart) begin
                // fresh scan from bin 0
                // an all-zero histogram ends up reporting bin 0
                scanActive <= 1'b1;
                scanAddr   <= '0;
                maxCount   <= '0;
                bestAddr   <= '0;
            end else if (scanActive) begin
                // strictly greater only, so ties stay with the lower bin
                if (scanCount > maxCount) begin
                    maxCount <= scanCount;
                    bestAddr <= scanAddr;
                end
                if (scanAddr == lastBin) begin
                    // one bin per cycle, done after the last one
                    scanActive <= 1'b0;
                    peakDone   <= 1'b1;
                end else begin
                    scanAddr <= scanAddr + 1'b1;
                end
            end
        end
    end

endmodule

//--- design/windowCalc.sv
`timescale 1ns/1ps

module windowCalc import hisPkg::*; #(
    parameter int stampWidth = 10,
    parameter int binBits    = 3
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  hisPhaseT              phase,
    input  logic                  peakDone,
    input  logic [binBits-1:0]    peakBin,
    input  logic                  resAck,
    output logic [binBits-1:0]    windowBase,
    output logic [binBits-1:0]    peakCoarse,
    output logic [binBits-1:0]    peakFine,
    output logic [stampWidth-1:0] peakStamp,
    output logic                  resReq,
    output logic                  resDone
);

    localparam int fineShift = stampWidth - 2 * binBits;
    // middle of a fine bin in stamp units
    localparam logic [stampWidth-1:0] binCentre = stampWidth'((1 << fineShift) >> 1);

    // result port sequencing
    typedef enum logic [1:0] {
        rsIdle    = 2'd0,
        rsReq     = 2'd1,
        rsRelease = 2'd2
    } resStateT;

    resStateT           resState;
    logic [binBits-1:0] coarseBin;
    logic [binBits-1:0] fineBin;

    // coarse peak is both the window and the reported coarse result
    assign windowBase = coarseBin;
    assign peakCoarse = coarseBin;
    assign peakFine   = fineBin;

    // coarse bin on top, fine bin below it, centre offset in the low bits
    assign peakStamp = (stampWidth'(coarseBin) << (stampWidth - binBits))
                     | (stampWidth'(fineBin) << fineShift)
                     | binCentre;

    assign resReq  = (resState == rsReq);
    // ack back low closes the exchange
    assign resDone = (resState == rsRelease) && !resAck;

    // peak latches
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            coarseBin <= '0;
            fineBin   <= '0;
        end else if (peakDone) begin
            if (phase == phaseCoarse) begin
                coarseBin <= peakBin;
            end else begin
                fineBin <= peakBin;
            end
        end
    end

    // four-phase req/ack
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resState <= rsIdle;
        end else begin
            case (resState)
                rsIdle: begin
                    // result valid once the fine peak is in
                    if (peakDone && phase == phaseFine) begin
                        resState <= rsReq;
                    end
                end
                rsReq: begin
                    // data held stable until ack seen
                    if (resAck) begin
                        resState <= rsRelease;
                    end
                end
                rsRelease: begin
                    if (!resAck) begin
                        resState <= rsIdle;
                    end
                end
                default: begin
                    resState <= rsIdle;
                end
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge by the log

verilator --binary --timing --assert -f tb.f --top-module tbHisBuilder -o simHisBuilder \
    && ./obj_dir/simHisBuilder > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log

grep -qx "No errors" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

//--- tb.f
design/hisPkg.sv
design/binMapper.sv
design/hisAccumulator.sv
design/peakFinder.sv
design/windowCalc.sv
design/hisBuilder.sv
test/tbHisBuilder.sv

//--- test/tbHisBuilder.sv
`timescale 1ns/1ps

module tbHisBuilder;

    localparam int stampWidth = 10;
    localparam int binBits    = 3;
    localparam int countWidth = 8;
    localparam int acqLength  = 16;
    localparam int numBins    = 2 ** binBits;
    localparam int fineShift  = stampWidth - 2 * binBits;
    localparam int countMax   = 2 ** countWidth - 1;
    // second builder with a pass longer than a bin can count
    localparam int satLength  = 300;
    localparam int maxGap     = 3;
    localparam int maxDelay   = 7;
    // worst case two-pass run with gapped strobes plus both scans and the handshake
    localparam int runBudget  = 2 * acqLength * (maxGap + 1) + 2 * (numBins + 4) + 20
                              + 2 * (maxDelay + 2);
    localparam int satBudget  = 2 * satLength + 2 * (numBins + 4) + 20 + 2 * (maxDelay + 2);
    // nine normal runs plus the saturation run and reset time
    localparam int cycleLimit = 20 + 9 * runBudget + satBudget;

    logic                  clk;
    logic                  rstN;
    logic                  wrEn;
    logic [stampWidth-1:0] roughData;
    logic                  resAck;
    logic                  useSat;
    logic [binBits-1:0]    peakCoarseM;
    logic [binBits-1:0]    peakFineM;
    logic [stampWidth-1:0] peakStampM;
    logic                  resReqM;
    logic                  busyM;
    logic [binBits-1:0]    peakCoarseS;
    logic [binBits-1:0]    peakFineS;
    logic [stampWidth-1:0] peakStampS;
    logic                  resReqS;
    logic                  busyS;

    // outputs of whichever builder is under test
    logic [binBits-1:0]    peakCoarse;
    logic [binBits-1:0]    peakFine;
    logic [stampWidth-1:0] peakStamp;
    logic                  resReq;
    logic                  busy;

    logic [stampWidth-1:0] coarseQ [$];
    logic [stampWidth-1:0] fineQ [$];
    integer                seed;
    int                    errCount;
    int                    testErrStart;
    int                    passCount;
    int                    failCount;
    int                    cycleCount;

    hisBuilder i_hisBuilder (
        .clk        (clk),
        .rstN       (rstN),
        .wrEn       (wrEn & !useSat),
        .roughData  (roughData),
        .peakCoarse (peakCoarseM),
        .peakFine   (peakFineM),
        .peakStamp  (peakStampM),
        .resReq     (resReqM),
        .resAck     (resAck),
        .busy       (busyM)
    );

    // held in reset except during the saturation run
    hisBuilder #(
        .acqLength (satLength)
    ) i_hisBuilderSat (
        .clk        (clk),
        .rstN       (rstN & useSat),
        .wrEn       (wrEn & useSat),
        .roughData  (roughData),
        .peakCoarse (peakCoarseS),
        .peakFine   (peakFineS),
        .peakStamp  (peakStampS),
        .resReq     (resReqS),
        .resAck     (resAck),
        .busy       (busyS)
    );

    assign peakCoarse = useSat ? peakCoarseS : peakCoarseM;
    assign peakFine   = useSat ? peakFineS : peakFineM;
    assign peakStamp  = useSat ? peakStampS : peakStampM;
    assign resReq     = useSat ? resReqS : resReqM;
    assign busy       = useSat ? busyS : busyM;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // request and result hold still until ack arrives
    assert property (@(posedge clk) disable iff (!rstN)
        (resReq && !resAck) |=> (resReq && $stable(peakStamp) && $stable(peakCoarse)
                                 && $stable(peakFine)))
    else begin
        errCount++;
        $display("error at %0t: request dropped or result changed before ack", $time);
    end

    // req only falls after an ack
    assert property (@(posedge clk) disable iff (!rstN) $fell(resReq) |-> $past(resAck))
    else begin
        errCount++;
        $display("error at %0t: resReq fell without resAck", $time);
    end

    // input is closed while a result is offered or acked
    assert property (@(posedge clk) disable iff (!rstN) (resReq || resAck) |-> busy)
    else begin
        errCount++;
        $display("error at %0t: builder collecting during the result exchange", $time);
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("Errors found");
        $finish;
    end

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [stampWidth-1:0] makeStamp(input int c, input int f, input int low);
        return stampWidth'((c << (stampWidth - binBits)) | (f << fineShift) | low);
    endfunction

    // reference histogram with lowest-bin tie break and counts stopping at countMax
    function automatic int modelPeak(input bit finePass, input int window);
        int                    hist [numBins];
        int                    best;
        int                    n;
        int                    c;
        int                    f;
        logic [stampWidth-1:0] s;
        for (int b = 0; b < numBins; b++) begin
            hist[b] = 0;
        end
        n = finePass ? fineQ.size() : coarseQ.size();
        for (int i = 0; i < n; i++) begin
            s = finePass ? fineQ[i] : coarseQ[i];
            c = int'(s >> (stampWidth - binBits));
            f = int'(s >> fineShift) % numBins;
            if (!finePass) begin
                if (hist[c] < countMax) begin
                    hist[c]++;
                end
            end else if (c == window && hist[f] < countMax) begin
                // out-of-window stamps are not counted
                hist[f]++;
            end
        end
        best = 0;
        for (int b = 1; b < numBins; b++) begin
            if (hist[b] > hist[best]) begin
                best = b;
            end
        end
        return best;
    endfunction

    task automatic checkValue(input string what, input int got, input int want);
        assert (got == want) else begin
            errCount++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    // n stamps in coarse bin c and fine bin f or spread over fine bins when f < 0
    task automatic addStamps(input bit finePass, input int c, input int f, input int n);
        logic [stampWidth-1:0] s;
        for (int i = 0; i < n; i++) begin
            s = makeStamp(c, (f < 0) ? i % numBins : f, (i * 5) % (1 << fineShift));
            if (finePass) begin
                fineQ.push_back(s);
            end else begin
                coarseQ.push_back(s);
            end
        end
    endtask

    task automatic sendPass(input bit finePass, input int gapMax);
        int n;
        int lat;
        n = finePass ? fineQ.size() : coarseQ.size();
        for (int i = 0; i < n; i++) begin
            repeat (randBelow(gapMax + 1)) @(negedge clk);
            assert (!busy && !resReq) else begin
                errCount++;
                $display("error at %0t: builder not collecting before strobe %0d", $time, i);
            end
            wrEn      = 1'b1;
            roughData = finePass ? fineQ[i] : coarseQ[i];
            @(negedge clk);
            wrEn = 1'b0;
        end
        // last strobe to scanStart plus the scan and one cycle to react
        lat = 0;
        while (finePass ? !resReq : busy) begin
            lat++;
            @(negedge clk);
        end
        checkValue(finePass ? "resReq latency" : "coarse scan length", lat, numBins + 2);
    endtask

    task automatic runTwoPass(input int gapMax, input int ackMax, input bit holdStrobes);
        int wantCoarse;
        int wantFine;
        int wantStamp;
        int lowStamp;
        int highStamp;
        wantCoarse = modelPeak(1'b0, 0);
        wantFine   = modelPeak(1'b1, wantCoarse);
        // centre of the fine bin is the midpoint of its stamp range
        lowStamp   = int'(makeStamp(wantCoarse, wantFine, 0));
        highStamp  = int'(makeStamp(wantCoarse, wantFine, (1 << fineShift) - 1));
        wantStamp  = (lowStamp + highStamp + 1) / 2;
        while (busy) begin
            @(negedge clk);
        end
        sendPass(1'b0, gapMax);
        sendPass(1'b1, gapMax);
        checkValue("peakCoarse", int'(peakCoarse), wantCoarse);
        checkValue("peakFine", int'(peakFine), wantFine);
        checkValue("peakStamp", int'(peakStamp), wantStamp);
        // stamps sent while ack is held back must be dropped
        repeat (1 + randBelow(ackMax)) begin
            if (holdStrobes) begin
                wrEn      = 1'b1;
                roughData = stampWidth'($random(seed));
            end
            @(negedge clk);
        end
        wrEn   = 1'b0;
        resAck = 1'b1;
        @(negedge clk);
        while (resReq) begin
            @(negedge clk);
        end
        repeat (randBelow(ackMax + 1)) @(negedge clk);
        resAck = 1'b0;
        @(negedge clk);
    endtask

    task automatic finishTest(input string name);
        if (errCount == testErrStart) begin
            passCount++;
            $display("test %s: passed", name);
        end else begin
            failCount++;
            $display("test %s: failed, %0d checks wrong", name, errCount - testErrStart);
        end
        testErrStart = errCount;
        coarseQ.delete();
        fineQ.delete();
    endtask

    initial begin
        int                    cp;
        logic [stampWidth-1:0] s;
        seed         = 32'hf0bb0d9b;
        errCount     = 0;
        testErrStart = 0;
        passCount    = 0;
        failCount    = 0;
        rstN         = 1'b0;
        wrEn         = 1'b0;
        roughData    = '0;
        resAck       = 1'b0;
        useSat       = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;

        repeat (5) begin
            @(negedge clk);
            assert (!busy && !resReq) else begin
                errCount++;
                $display("error at %0t: busy or resReq high after reset", $time);
            end
        end
        finishTest("after reset");

        addStamps(1'b0, 5, -1, 12);
        addStamps(1'b0, 1, -1, 4);
        addStamps(1'b1, 5, 3, 10);
        addStamps(1'b1, 5, 6, 6);
        runTwoPass(0, 1, 1'b0);
        finishTest("coarse and fine peak");

        // outside stamps would make fine bin 4 win if counted
        addStamps(1'b0, 2, -1, 10);
        addStamps(1'b0, 7, -1, 6);
        addStamps(1'b1, 2, 1, 6);
        addStamps(1'b1, 5, 4, 7);
        addStamps(1'b1, 2, 4, 3);
        runTwoPass(maxGap, 2, 1'b0);
        finishTest("window filter");

        addStamps(1'b0, 6, -1, 6);
        addStamps(1'b0, 3, -1, 6);
        addStamps(1'b0, 0, -1, 4);
        addStamps(1'b1, 3, 7, 5);
        addStamps(1'b1, 3, 2, 5);
        addStamps(1'b1, 1, 2, 6);
        runTwoPass(0, 2, 1'b0);
        coarseQ.delete();
        fineQ.delete();
        // a wrapped count would lose to the 40 hits
        useSat = 1'b1;
        addStamps(1'b0, 2, -1, 260);
        addStamps(1'b0, 1, 0, 40);
        addStamps(1'b1, 2, 6, 260);
        addStamps(1'b1, 2, 3, 40);
        runTwoPass(0, 2, 1'b0);
        useSat = 1'b0;
        finishTest("tie and saturation");

        addStamps(1'b0, 4, -1, 16);
        addStamps(1'b1, 4, 5, 9);
        addStamps(1'b1, 4, 0, 7);
        runTwoPass(0, maxDelay, 1'b1);
        coarseQ.delete();
        fineQ.delete();
        addStamps(1'b0, 0, -1, 8);
        addStamps(1'b0, 7, -1, 8);
        addStamps(1'b1, 0, 0, 6);
        addStamps(1'b1, 0, 1, 5);
        addStamps(1'b1, 0, 2, 5);
        runTwoPass(0, maxDelay, 1'b0);
        finishTest("result handshake");

        for (int r = 0; r < 4; r++) begin
            coarseQ.delete();
            fineQ.delete();
            for (int i = 0; i < acqLength; i++) begin
                coarseQ.push_back(stampWidth'($random(seed)));
            end
            cp = modelPeak(1'b0, 0);
            for (int i = 0; i < acqLength; i++) begin
                s = stampWidth'($random(seed));
                // about half land in the window
                if (randBelow(2) == 0) begin
                    s = makeStamp(cp, int'(s >> fineShift) % numBins,
                                  int'(s) % (1 << fineShift));
                end
                fineQ.push_back(s);
            end
            runTwoPass(maxGap, maxDelay, 1'b0);
        end
        finishTest("random runs");

        $display("tests passed %0d, tests failed %0d, checks wrong %0d",
                 passCount, failCount, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
